//--- flist.f
+incdir+logic
logic/rvvi_pkg.sv
logic/retire_ctrl.sv
logic/retire_trace.sv
logic/csr_merge.sv
logic/net_events.sv
logic/irq_watch.sv
logic/rvfi_rvvi_bridge.sv
verif/rvvi_properties.sv
verif/tb_rvfi_rvvi_bridge.sv

//--- logic/csr_merge.sv
// CSR write/read merge with per-retirement change flags
`include "rvvi_defines.svh"

module csr_merge (
   input  logic                  rvvi,
   input  logic                  rst_n,
   input  logic                  capture,
   input  rvvi_pkg::csr_port_t   csr [`RVVI_NUM_CSR],
   output logic [`RVVI_XLEN-1:0] csr_value [`RVVI_NUM_CSR],
   output logic [`RVVI_NUM_CSR-1:0] csr_wb
);

   // Architectural value after the retiring instruction
   logic [`RVVI_XLEN-1:0]    merged [`RVVI_NUM_CSR];
   logic [`RVVI_NUM_CSR-1:0] differs;

   ////////////////////////////////////////
   // Merge
   ////////////////////////////////////////

   // Written bits come from wdata, untouched bits keep rdata
   always_comb begin
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         merged[i]  = (csr[i].wdata & csr[i].wmask) |
                      (csr[i].rdata & ~csr[i].wmask);
         differs[i] = (merged[i] != csr_value[i]);
      end
   end

   ////////////////////////////////////////
   // Stored values and flags
   ////////////////////////////////////////

   // Values start at zero, so a nonzero first capture is flagged
   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            csr_value[i] <= '0;
         end
         csr_wb <= '0;
      end else if (capture) begin
         for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            csr_value[i] <= merged[i];
         end
         csr_wb <= differs;
      end
   end

endmodule

//--- logic/irq_watch.sv
// Interrupt line sampler with a one-cycle change mask
`include "rvvi_defines.svh"

module irq_watch (
   input  logic                     rvvi,
   input  logic                     rst_n,
   input  logic [`RVVI_NUM_IRQ-1:0] irq,
   output logic [`RVVI_NUM_IRQ-1:0] irq_level,
   output logic [`RVVI_NUM_IRQ-1:0] irq_change
);

   logic [`RVVI_NUM_IRQ-1:0] irq_impl;

   // Lines the core does not implement never show up
   assign irq_impl = irq & `RVVI_IRQ_IMPL_MASK;

   // irq_level holds the previous sample, so the XOR marks edges
   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         irq_level  <= '0;
         irq_change <= '0;
      end else begin
         irq_change <= irq_impl ^ irq_level;
         irq_level  <= irq_impl;
      end
   end

endmodule

//--- logic/net_events.sv
// Halt request, NMI and instruction bus fault levels updated per retirement
`include "rvvi_defines.svh"

module net_events (
   input  logic                   rvvi,
   input  logic                   rst_n,
   input  logic                   capture,
   input  rvvi_pkg::rvfi_retire_t retire,
   output rvvi_pkg::net_events_t  events
);

   logic nmi_cause_hit;
   logic nmi_next;
   logic halt_next;
   logic ibus_next;

   ////////////////////////////////////////
   // Level decode
   ////////////////////////////////////////

   // Debug entry caused by haltreq while in debug mode
   assign halt_next = (retire.dbg == `RVVI_DBG_HALTREQ) && retire.dbg_mode;

   // Load or store bus error taken as NMI
   assign nmi_cause_hit = retire.intr.intr && retire.intr.interrupt &&
                          ((retire.intr.cause == `RVVI_NMI_LOAD_CAUSE) ||
                           (retire.intr.cause == `RVVI_NMI_STORE_CAUSE));

   // A pending NMI counts even before the handler is entered
   assign nmi_next = nmi_cause_hit || retire.nmip[0];

   assign ibus_next = retire.trap.trap && retire.trap.exception &&
                      (retire.trap.exception_cause == `RVVI_EXC_IBUS_FAULT);

   ////////////////////////////////////////
   // Level registers
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         events <= '0;
      end else if (capture) begin
         events.haltreq    <= halt_next;
         events.nmi        <= nmi_next;
         events.ibus_fault <= ibus_next;
         // Cause is kept once the NMI level drops
         if (nmi_next) begin
            events.nmi_cause <= retire.intr.cause;
         end
      end
   end

endmodule

//--- logic/retire_ctrl.sv
// Retirement novelty detector that issues the capture strobe
`include "rvvi_defines.svh"

module retire_ctrl (
   input  logic                   rvvi,
   input  logic                   rst_n,
   input  rvvi_pkg::rvfi_retire_t retire,
   output logic                   capture
);

   // Order of the last retirement passed downstream
   logic [`RVVI_ORDER_W-1:0] last_order;

   // Set once the first retirement after reset has been taken
   logic                     seen;

   logic                     order_new;

   ////////////////////////////////////////
   // Novelty test
   ////////////////////////////////////////

   // The core may hold valid with the same order for several cycles
   assign order_new = !seen || (retire.order != last_order);
   assign capture   = retire.valid && order_new;

   ////////////////////////////////////////
   // Order tracking
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         seen       <= 1'b0;
         last_order <= '0;
      end else if (capture) begin
         seen       <= 1'b1;
         last_order <= retire.order;
      end
   end

endmodule

//--- logic/retire_trace.sv
// Trace record and GPR write-back registers loaded on each capture
`include "rvvi_defines.svh"

module retire_trace (
   input  logic                   rvvi,
   input  logic                   rst_n,
   input  logic                   capture,
   input  rvvi_pkg::rvfi_retire_t retire,
   output rvvi_pkg::rvvi_trace_t  trace,
   output rvvi_pkg::gpr_wb_t      gpr
);

   logic                      ibus_trap;
   logic [`RVVI_NUM_GPR-1:0]  wb_onehot;
   logic [`RVVI_XLEN-1:0]     wb_data;

   ////////////////////////////////////////
   // Next record
   ////////////////////////////////////////

   // Only the externally raised fetch fault is flagged as a trap,
   // every other trap is derived by the reference model itself
   assign ibus_trap = retire.trap.trap &&
                      (retire.trap.exception_cause == `RVVI_EXC_IBUS_FAULT);

   always_comb begin
      wb_onehot                  = '0;
      wb_onehot[retire.rd1_addr] = 1'b1;
   end

   // x0 always reads back as zero
   assign wb_data = (retire.rd1_addr == '0) ? '0 : retire.rd1_wdata;

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         trace.valid <= 1'b0;
      end else begin
         // One cycle per new retirement
         trace.valid <= capture;
      end

      if (capture) begin
         trace.order    <= retire.order;
         trace.insn     <= retire.insn;
         trace.trap     <= ibus_trap;
         trace.intr     <= retire.intr;
         trace.mode     <= retire.mode;
         trace.ixl      <= retire.ixl;
         trace.pc_rdata <= retire.pc_rdata;
         trace.pc_wdata <= retire.pc_wdata;

         gpr.x_wb       <= wb_onehot;
         gpr.x_wdata    <= wb_data;
      end
   end

endmodule

//--- logic/rvfi_rvvi_bridge.sv
// Top level of the RVFI to RVVI trace bridge
`include "rvvi_defines.svh"

module rvfi_rvvi_bridge (
   input  logic                     rvvi,
   input  logic                     rst_n,
   input  rvvi_pkg::rvfi_retire_t   retire,
   input  rvvi_pkg::csr_port_t      csr [`RVVI_NUM_CSR],
   input  logic [`RVVI_NUM_IRQ-1:0] irq,
   output rvvi_pkg::rvvi_trace_t    trace,
   output rvvi_pkg::gpr_wb_t        gpr,
   output logic [`RVVI_XLEN-1:0]    csr_value [`RVVI_NUM_CSR],
   output logic [`RVVI_NUM_CSR-1:0] csr_wb,
   output rvvi_pkg::net_events_t    events,
   output logic [`RVVI_NUM_IRQ-1:0] irq_level,
   output logic [`RVVI_NUM_IRQ-1:0] irq_change
);

   // High in the cycle a new retirement is sampled
   logic capture;

   retire_ctrl u_retire_ctrl (
      .rvvi    (rvvi),
      .rst_n   (rst_n),
      .retire  (retire),
      .capture (capture)
   );

   retire_trace u_retire_trace (
      .rvvi    (rvvi),
      .rst_n   (rst_n),
      .capture (capture),
      .retire  (retire),
      .trace   (trace),
      .gpr     (gpr)
   );

   csr_merge u_csr_merge (
      .rvvi      (rvvi),
      .rst_n     (rst_n),
      .capture   (capture),
      .csr       (csr),
      .csr_value (csr_value),
      .csr_wb    (csr_wb)
   );

   net_events u_net_events (
      .rvvi    (rvvi),
      .rst_n   (rst_n),
      .capture (capture),
      .retire  (retire),
      .events  (events)
   );

   // Interrupt lines run independently of retirement
   irq_watch u_irq_watch (
      .rvvi       (rvvi),
      .rst_n      (rst_n),
      .irq        (irq),
      .irq_level  (irq_level),
      .irq_change (irq_change)
   );

endmodule

//--- logic/rvvi_defines.svh
// Width, count and cause-code macros for the RVFI to RVVI trace bridge
`ifndef RVVI_DEFINES_SVH
`define RVVI_DEFINES_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data and program counter width
`define RVVI_XLEN            32

// Retirement order counter width
`define RVVI_ORDER_W         64

// General purpose register file
`define RVVI_NUM_GPR         32
`define RVVI_GPR_ADDR_W      5

// Cause field widths as carried on the retirement port
`define RVVI_EXC_CAUSE_W     6
`define RVVI_INTR_CAUSE_W    11
`define RVVI_DBG_W           3

////////////////////////////////////////
// Counts and masks
////////////////////////////////////////

`define RVVI_NUM_CSR         8
`define RVVI_NUM_IRQ         32

// Lines 3, 7, 11 and the local interrupts 16 to 31
`define RVVI_IRQ_IMPL_MASK   32'hFFFF_0888

////////////////////////////////////////
// Cause codes
////////////////////////////////////////

// Instruction bus fault, raised outside the core
`define RVVI_EXC_IBUS_FAULT  6'd48

// Data bus fault NMIs
`define RVVI_NMI_LOAD_CAUSE  11'd1024
`define RVVI_NMI_STORE_CAUSE 11'd1025

// Debug entry through an external halt request
`define RVVI_DBG_HALTREQ     3'd3

`endif

//--- logic/rvvi_pkg.sv
// Shared structs for the retirement port, trace record, GPR write-back, events and CSR slots
`include "rvvi_defines.svh"

package rvvi_pkg;

   ////////////////////////////////////////
   // Retirement port side
   ////////////////////////////////////////

   // Trap information for the retiring instruction
   typedef struct packed {
      logic                          trap;
      logic                          exception;
      logic                          debug;
      logic [`RVVI_EXC_CAUSE_W-1:0]  exception_cause;
      logic [`RVVI_DBG_W-1:0]        debug_cause;
      logic [1:0]                    cause_type;
   } rvfi_trap_t;

   // First instruction of a handler carries this
   typedef struct packed {
      logic                          intr;
      logic                          exception;
      logic                          interrupt;
      logic [`RVVI_INTR_CAUSE_W-1:0] cause;
   } rvfi_intr_t;

   typedef struct packed {
      logic                          valid;
      logic [`RVVI_ORDER_W-1:0]      order;
      logic [`RVVI_XLEN-1:0]         insn;
      rvfi_trap_t                    trap;
      rvfi_intr_t                    intr;
      logic                          halt;
      logic [`RVVI_DBG_W-1:0]        dbg;
      logic                          dbg_mode;
      // Bit 0 is NMI pending, bit 1 selects store over load
      logic [1:0]                    nmip;
      logic [1:0]                    mode;
      logic [1:0]                    ixl;
      logic [`RVVI_XLEN-1:0]         pc_rdata;
      logic [`RVVI_XLEN-1:0]         pc_wdata;
      logic [`RVVI_GPR_ADDR_W-1:0]   rd1_addr;
      logic [`RVVI_XLEN-1:0]         rd1_wdata;
   } rvfi_retire_t;

   // One CSR as seen at retirement
   typedef struct packed {
      logic [`RVVI_XLEN-1:0]         wdata;
      logic [`RVVI_XLEN-1:0]         wmask;
      logic [`RVVI_XLEN-1:0]         rdata;
   } csr_port_t;

   ////////////////////////////////////////
   // Trace side
   ////////////////////////////////////////

   typedef struct packed {
      logic                          valid;
      logic [`RVVI_ORDER_W-1:0]      order;
      logic [`RVVI_XLEN-1:0]         insn;
      logic                          trap;
      rvfi_intr_t                    intr;
      logic [1:0]                    mode;
      logic [1:0]                    ixl;
      logic [`RVVI_XLEN-1:0]         pc_rdata;
      logic [`RVVI_XLEN-1:0]         pc_wdata;
   } rvvi_trace_t;

   typedef struct packed {
      logic [`RVVI_NUM_GPR-1:0]      x_wb;
      logic [`RVVI_XLEN-1:0]         x_wdata;
   } gpr_wb_t;

   typedef struct packed {
      logic                          haltreq;
      logic                          nmi;
      logic [`RVVI_INTR_CAUSE_W-1:0] nmi_cause;
      logic                          ibus_fault;
   } net_events_t;

   // Slot numbers of the merged CSRs
   typedef enum logic [2:0] {
      CSR_MSTATUS  = 3'd0,
      CSR_MISA     = 3'd1,
      CSR_MIE      = 3'd2,
      CSR_MTVEC    = 3'd3,
      CSR_MSCRATCH = 3'd4,
      CSR_MEPC     = 3'd5,
      CSR_MCAUSE   = 3'd6,
      CSR_MTVAL    = 3'd7
   } csr_idx_e;

endpackage

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f flist.f --top-module tb_rvfi_rvvi_bridge -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
   || { echo "Simulation did not pass"; exit 1; }

//--- verif/rvvi_properties.sv
// Concurrent checks on the trace valid pulse, the interrupt change mask and the reset state
`include "rvvi_defines.svh"

module rvvi_properties (
   input logic                     rvvi,
   input logic                     rst_n,
   input rvvi_pkg::rvvi_trace_t    trace,
   input logic [`RVVI_NUM_CSR-1:0] csr_wb,
   input rvvi_pkg::net_events_t    events,
   input logic [`RVVI_NUM_IRQ-1:0] irq_change
);
   timeunit 1ns;
   timeprecision 100ps;

   // One pulse per new retirement
   assert property (@(posedge rvvi) disable iff (!rst_n) trace.valid |=> !trace.valid)
      else $error("trace.valid high on two consecutive cycles");

   // Unimplemented lines are masked before the edge detect
   assert property (@(posedge rvvi) disable iff (!rst_n)
                    (irq_change & ~`RVVI_IRQ_IMPL_MASK) == '0)
      else $error("irq_change set on an unimplemented line");

   assert property (@(posedge rvvi) !rst_n |=>
                    !trace.valid && (csr_wb == '0) && (irq_change == '0) &&
                    !events.haltreq && !events.nmi && !events.ibus_fault)
      else $error("Control outputs not cleared after reset");

endmodule

bind rvfi_rvvi_bridge rvvi_properties u_rvvi_properties (
   .rvvi       (rvvi),
   .rst_n      (rst_n),
   .trace      (trace),
   .csr_wb     (csr_wb),
   .events     (events),
   .irq_change (irq_change)
);

//--- verif/tb_rvfi_rvvi_bridge.sv
// Testbench top with clock, reset, directed tests, compare tasks and timeout
`include "rvvi_defines.svh"

module tb_rvfi_rvvi_bridge;
   timeunit 1ns;
   timeprecision 100ps;

   // Length budget of all tests, doubled for the timeout
   localparam int TEST_CYCLES    = 200;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic                     rvvi = 1'b0;
   logic                     rst_n = 1'b0;
   rvvi_pkg::rvfi_retire_t   retire;
   rvvi_pkg::csr_port_t      csr [`RVVI_NUM_CSR];
   logic [`RVVI_NUM_IRQ-1:0] irq;
   rvvi_pkg::rvvi_trace_t    trace;
   rvvi_pkg::gpr_wb_t        gpr;
   logic [`RVVI_XLEN-1:0]    csr_value [`RVVI_NUM_CSR];
   logic [`RVVI_NUM_CSR-1:0] csr_wb;
   rvvi_pkg::net_events_t    events;
   logic [`RVVI_NUM_IRQ-1:0] irq_level;
   logic [`RVVI_NUM_IRQ-1:0] irq_change;

   integer                   seed = 82750;
   int                       errors, tests_ok, tests_bad, cycles;
   logic [`RVVI_ORDER_W-1:0] next_order = 64'd1;
   // Expected CSR values and event levels as of the last capture
   logic [`RVVI_XLEN-1:0]    csr_model [`RVVI_NUM_CSR];
   rvvi_pkg::net_events_t    exp_ev;

   rvfi_rvvi_bridge u_rvfi_rvvi_bridge (.*);

   always #2 rvvi = ~rvvi;

   always @(posedge rvvi) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic compare_trace(input rvvi_pkg::rvvi_trace_t exp, input logic valid_only);
      if (valid_only ? (trace.valid !== exp.valid) : (trace !== exp)) begin
         errors++;
         $display("** Error trace: expected %h, actual %h", exp, trace);
      end
   endtask

   task automatic compare_gpr(input rvvi_pkg::gpr_wb_t exp);
      if (gpr !== exp) begin
         errors++;
         $display("** Error gpr: expected %h, actual %h", exp, gpr);
      end
   endtask

   task automatic compare_csr(input rvvi_pkg::csr_idx_e slot, input logic [31:0] val,
                              input logic wb);
      if (csr_value[slot] !== val || csr_wb[slot] !== wb) begin
         errors++;
         $display("** Error csr_value[%0d]/csr_wb: expected %h/%h, actual %h/%h",
                  slot, val, wb, csr_value[slot], csr_wb[slot]);
      end
   endtask

   task automatic compare_events(input rvvi_pkg::net_events_t exp);
      if (events !== exp) begin
         errors++;
         $display("** Error events: expected %h, actual %h", exp, events);
      end
   endtask

   task automatic compare_irq(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // Random fields, no trap, interrupt or debug information
   task automatic plain_retire(output rvvi_pkg::rvfi_retire_t r);
      logic [31:0] rnd;
      r           = '0;
      r.valid     = 1'b1;
      r.order     = next_order;
      next_order  = next_order + 64'd1;
      r.insn      = $random(seed);
      r.pc_rdata  = $random(seed);
      r.pc_wdata  = $random(seed);
      r.rd1_wdata = $random(seed);
      rnd         = $random(seed);
      r.mode      = rnd[1:0];
      r.ixl       = rnd[3:2];
      r.rd1_addr  = rnd[8:4];
   endtask

   // Idle cycle first, then one cycle of valid, so trace.valid never pulses twice in a row
   task automatic retire_step(input rvvi_pkg::rvfi_retire_t r);
      @(negedge rvvi);
      retire = r;
      @(negedge rvvi);
      retire.valid = 1'b0;
   endtask

   function automatic rvvi_pkg::rvvi_trace_t expect_trace(input rvvi_pkg::rvfi_retire_t r);
      rvvi_pkg::rvvi_trace_t t;
      t.valid    = 1'b1;
      t.order    = r.order;
      t.insn     = r.insn;
      // Raised only by the fetch fault test
      t.trap     = 1'b0;
      t.intr     = r.intr;
      t.mode     = r.mode;
      t.ixl      = r.ixl;
      t.pc_rdata = r.pc_rdata;
      t.pc_wdata = r.pc_wdata;
      return t;
   endfunction

   function automatic rvvi_pkg::gpr_wb_t expect_gpr(input rvvi_pkg::rvfi_retire_t r);
      rvvi_pkg::gpr_wb_t g;
      g.x_wb    = 32'd1 << r.rd1_addr;
      g.x_wdata = (r.rd1_addr == 5'd0) ? 32'd0 : r.rd1_wdata;
      return g;
   endfunction

   task automatic end_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         tests_ok++;
         $display("Test %s finished without errors", name);
      end else begin
         tests_bad++;
         $display("Test %s finished with %0d errors", name, errors - errors_before);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_reset();
      int e0;
      e0     = errors;
      exp_ev = '0;
      compare_trace('0, 1'b1);
      compare_events(exp_ev);
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         compare_csr(rvvi_pkg::csr_idx_e'(i[2:0]), 32'd0, 1'b0);
      end
      compare_irq("irq_change", 32'd0, irq_change);
      compare_irq("irq_level", 32'd0, irq_level);
      end_test("reset", e0);
   endtask

   task automatic test_retire();
      int                     e0;
      rvvi_pkg::rvfi_retire_t r;
      rvvi_pkg::rvvi_trace_t  t;
      e0 = errors;
      plain_retire(r);
      r.rd1_addr = 5'd9;
      retire_step(r);
      compare_trace(expect_trace(r), 1'b0);
      compare_gpr(expect_gpr(r));
      // x0 write shows mask bit 0 and zero data
      plain_retire(r);
      r.rd1_addr  = 5'd0;
      r.rd1_wdata = 32'hDEAD_BEEF;
      retire_step(r);
      t = expect_trace(r);
      compare_trace(t, 1'b0);
      compare_gpr(expect_gpr(r));
      // Same order again, then a new order with valid low
      retire_step(r);
      t.valid = 1'b0;
      compare_trace(t, 1'b0);
      plain_retire(r);
      r.valid = 1'b0;
      retire_step(r);
      compare_trace(t, 1'b0);
      end_test("retire", e0);
   endtask

   task automatic test_csr();
      int                     e0;
      rvvi_pkg::rvfi_retire_t r;
      logic [31:0]            merged [`RVVI_NUM_CSR];
      e0 = errors;
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         csr[i[2:0]].wdata = $random(seed);
         csr[i[2:0]].wmask = $random(seed);
         csr[i[2:0]].rdata = $random(seed);
         // Each bit from wdata where the mask is set, from rdata elsewhere
         for (int b = 0; b < `RVVI_XLEN; b++) begin
            merged[i[2:0]][b] = csr[i[2:0]].wmask[b] ? csr[i[2:0]].wdata[b]
                                                     : csr[i[2:0]].rdata[b];
         end
      end
      plain_retire(r);
      retire_step(r);
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         compare_csr(rvvi_pkg::csr_idx_e'(i[2:0]), merged[i[2:0]],
                     merged[i[2:0]] != csr_model[i[2:0]]);
         csr_model[i[2:0]] = merged[i[2:0]];
      end
      plain_retire(r);
      retire_step(r);
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         compare_csr(rvvi_pkg::csr_idx_e'(i[2:0]), merged[i[2:0]], 1'b0);
      end
      end_test("csr_merge", e0);
   endtask

   task automatic test_nmi_fault();
      int                     e0;
      rvvi_pkg::rvfi_retire_t r;
      rvvi_pkg::rvvi_trace_t  t;
      e0 = errors;
      // Pending NMI alone, the handler cause is still zero
      plain_retire(r);
      r.nmip = 2'b01;
      retire_step(r);
      exp_ev.nmi       = 1'b1;
      exp_ev.nmi_cause = 11'd0;
      compare_events(exp_ev);
      plain_retire(r);
      r.intr.intr      = 1'b1;
      r.intr.interrupt = 1'b1;
      r.intr.cause     = `RVVI_NMI_STORE_CAUSE;
      retire_step(r);
      exp_ev.nmi_cause = `RVVI_NMI_STORE_CAUSE;
      compare_events(exp_ev);
      plain_retire(r);
      retire_step(r);
      exp_ev.nmi = 1'b0;
      compare_events(exp_ev);
      plain_retire(r);
      r.trap.trap            = 1'b1;
      r.trap.exception       = 1'b1;
      r.trap.exception_cause = `RVVI_EXC_IBUS_FAULT;
      retire_step(r);
      exp_ev.ibus_fault = 1'b1;
      compare_events(exp_ev);
      t      = expect_trace(r);
      t.trap = 1'b1;
      compare_trace(t, 1'b0);
      plain_retire(r);
      retire_step(r);
      exp_ev.ibus_fault = 1'b0;
      compare_events(exp_ev);
      compare_trace(expect_trace(r), 1'b0);
      end_test("nmi_fault", e0);
   endtask

   task automatic test_halt();
      int                     e0;
      rvvi_pkg::rvfi_retire_t r;
      e0 = errors;
      plain_retire(r);
      r.dbg      = `RVVI_DBG_HALTREQ;
      r.dbg_mode = 1'b1;
      retire_step(r);
      exp_ev.haltreq = 1'b1;
      compare_events(exp_ev);
      plain_retire(r);
      r.dbg = `RVVI_DBG_HALTREQ;
      retire_step(r);
      exp_ev.haltreq = 1'b0;
      compare_events(exp_ev);
      end_test("halt", e0);
   endtask

   task automatic test_irq();
      int e0;
      e0  = errors;
      // Lines 3, 7 and 20 rise together
      irq = 32'h0010_0088;
      @(negedge rvvi);
      compare_irq("irq_change", 32'h0010_0088, irq_change);
      compare_irq("irq_level", 32'h0010_0088, irq_level);
      @(negedge rvvi);
      compare_irq("irq_change", 32'd0, irq_change);
      // Line 5 is not implemented
      irq = irq ^ 32'h0000_0020;
      @(negedge rvvi);
      compare_irq("irq_change", 32'd0, irq_change);
      compare_irq("irq_level", 32'h0010_0088, irq_level);
      end_test("irq_watch", e0);
   endtask

   initial begin
      retire = '0;
      irq    = '0;
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         csr[i[2:0]]       = '0;
         csr_model[i[2:0]] = '0;
      end
      repeat (4) @(posedge rvvi);
      @(negedge rvvi);
      rst_n = 1'b1;
      test_reset();
      test_retire();
      test_csr();
      test_nmi_fault();
      test_halt();
      test_irq();
      $display("Tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
      if (tests_bad == 0 && errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
